//--- design/fc_lcc_svc_pkg.sv
//--------------------------------------------------------------------------
// Layout assumes 8-word partitions with the digest in the last word, and
// a 64-word OTP image of which the first 7 partitions are used
//--------------------------------------------------------------------------
`default_nettype none

package fc_lcc_svc_pkg;

  // Widths that carry a meaning
  typedef logic [7:0]  svc_cmd_t;
  typedef logic [1:0]  clk_sel_t;
  typedef logic [15:0] otp_word_t;
  typedef logic [5:0]  otp_addr_t;
  typedef logic [31:0] rom_mask_t;

  //------------------------------------------------------------------------
  // Service command codes, anything else is ignored
  //------------------------------------------------------------------------
  localparam svc_cmd_t CMD_SUB_RESET        = 8'h10;
  localparam svc_cmd_t CMD_CLK_500          = 8'h20;
  localparam svc_cmd_t CMD_CLK_160          = 8'h21;
  localparam svc_cmd_t CMD_CLK_400          = 8'h22;
  localparam svc_cmd_t CMD_CLK_1000         = 8'h23;
  localparam svc_cmd_t CMD_ZERO_FORCE       = 8'h30;
  localparam svc_cmd_t CMD_ZERO_FORCE_RESET = 8'h31;
  localparam svc_cmd_t CMD_ZERO_RELEASE     = 8'h32;
  localparam svc_cmd_t CMD_FC_ESCALATE      = 8'h40;
  localparam svc_cmd_t CMD_SCRAP_ESC0       = 8'h50;
  localparam svc_cmd_t CMD_SCRAP_ESC0_DIS   = 8'h51;
  localparam svc_cmd_t CMD_SCRAP_ESC1       = 8'h52;
  localparam svc_cmd_t CMD_SCRAP_ESC1_DIS   = 8'h53;
  localparam svc_cmd_t CMD_SVA_DISABLE      = 8'h60;
  localparam svc_cmd_t CMD_SVA_ENABLE       = 8'h61;
  localparam svc_cmd_t CMD_FAULT_CORR       = 8'h70;
  localparam svc_cmd_t CMD_FAULT_UNCORR     = 8'h71;
  localparam svc_cmd_t CMD_FAULT_DIGEST     = 8'h72;

  // External clock frequency codes, 1000 MHz is the reset choice
  localparam clk_sel_t CLK_SEL_1000 = 2'd0;
  localparam clk_sel_t CLK_SEL_500  = 2'd1;
  localparam clk_sel_t CLK_SEL_400  = 2'd2;
  localparam clk_sel_t CLK_SEL_160  = 2'd3;

  typedef enum logic [1:0] {
    ZM_PASS      = 2'd0,
    ZM_FORCE     = 2'd1,
    ZM_FORCE_RST = 2'd2
  } zero_mode_t;

  //------------------------------------------------------------------------
  // OTP partition layout
  //------------------------------------------------------------------------
  localparam int OTP_WORDS     = 64;
  localparam int NUM_PARTS     = 7;
  localparam int PART_WORDS    = 8;
  localparam int PART_SHIFT    = $clog2(PART_WORDS);
  localparam int LC_TRANS_PART = 5;

  typedef logic [$bits(otp_addr_t)-PART_SHIFT-1:0] part_idx_t;

  localparam part_idx_t LAST_PART      = part_idx_t'(NUM_PARTS - 1);
  localparam otp_addr_t LC_DIGEST_ADDR =
    otp_addr_t'(LC_TRANS_PART * PART_WORDS + PART_WORDS - 1);

  // Subsystem reset stretch
  localparam int RST_HOLD_CYCLES = 11;

  typedef logic [$clog2(RST_HOLD_CYCLES + 1)-1:0] rst_cnt_t;

  localparam rst_cnt_t RST_HOLD_CNT = rst_cnt_t'(RST_HOLD_CYCLES);

endpackage

`default_nettype wire

//--- design/svc_cmd_if.sv
//--------------------------------------------------------------------------
// Decoded command strobes, each high for exactly one cycle
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface svc_cmd_if
  import fc_lcc_svc_pkg::*;
();

  logic     rst_stb;
  logic     clk_stb;
  clk_sel_t clk_code;
  logic     fault_corr_stb;
  logic     fault_uncorr_stb;
  logic     digest_clr_stb;

  modport src (
    output rst_stb, clk_stb, clk_code,
    output fault_corr_stb, fault_uncorr_stb, digest_clr_stb
  );

  modport rst_sink (input rst_stb);

  modport clk_sink (input clk_stb, clk_code);

  modport fault_sink (input fault_corr_stb, fault_uncorr_stb, digest_clr_stb);

endinterface

`default_nettype wire

//--- design/otp_fault_if.sv
//--------------------------------------------------------------------------
// Raw partition words out of the store, fault overlay back into it
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface otp_fault_if
  import fc_lcc_svc_pkg::*;
();

  // First word of each partition and its lock state
  otp_word_t [NUM_PARTS-1:0] part_word;
  logic      [NUM_PARTS-1:0] digest_nz;

  // Overlay from the injector
  logic                      fault_active;
  otp_word_t [NUM_PARTS-1:0] faulted_word;
  logic                      digest_clr;

  modport store (output part_word, digest_nz, input fault_active, faulted_word, digest_clr);

  modport inject (input part_word, digest_nz, output fault_active, faulted_word, digest_clr);

endinterface

`default_nettype wire

//--- design/svc_cmd_decoder.sv
//--------------------------------------------------------------------------
// Commands have no back-pressure. Strobes appear two edges after the
// command, flags and the zeroization mode one edge after it
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module svc_cmd_decoder
  import fc_lcc_svc_pkg::*;
(
  input  logic       clk,
  input  logic       cptra_rst_b,
  input  logic       cmd_valid_i,
  input  svc_cmd_t   cmd_i,
  input  logic       zeroize_ppd_i,
  input  logic       scrap_mode_i,
  input  rom_mask_t  rom_zero_mask_i,
  svc_cmd_if.src     cmd_bus,
  output logic       fc_esc_o,
  output logic       scrap_esc0_o,
  output logic       scrap_esc1_o,
  output logic       sva_disable_o,
  output zero_mode_t zero_mode_o,
  output logic       zeroize_ppd_o,
  output logic       scrap_mode_o,
  output rom_mask_t  rom_zero_mask_o
);

  logic     valid_q;
  svc_cmd_t cmd_q;

  function automatic clk_sel_t clk_code_of(svc_cmd_t cmd);
    case (cmd)
      CMD_CLK_500: return CLK_SEL_500;
      CMD_CLK_160: return CLK_SEL_160;
      CMD_CLK_400: return CLK_SEL_400;
      default:     return CLK_SEL_1000;
    endcase
  endfunction

  // Command word and the clock code it selects, one register stage each
  always_ff @(posedge clk) begin
    cmd_q            <= cmd_i;
    cmd_bus.clk_code <= clk_code_of(cmd_q);
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      valid_q                  <= 1'b0;
      cmd_bus.rst_stb          <= 1'b0;
      cmd_bus.clk_stb          <= 1'b0;
      cmd_bus.fault_corr_stb   <= 1'b0;
      cmd_bus.fault_uncorr_stb <= 1'b0;
      cmd_bus.digest_clr_stb   <= 1'b0;
      fc_esc_o                 <= 1'b0;
      scrap_esc0_o             <= 1'b0;
      scrap_esc1_o             <= 1'b0;
      sva_disable_o            <= 1'b0;
      zero_mode_o              <= ZM_PASS;
    end else begin
      valid_q                  <= cmd_valid_i;
      cmd_bus.rst_stb          <= 1'b0;
      cmd_bus.clk_stb          <= 1'b0;
      cmd_bus.fault_corr_stb   <= 1'b0;
      cmd_bus.fault_uncorr_stb <= 1'b0;
      cmd_bus.digest_clr_stb   <= 1'b0;
      if (valid_q) begin
        case (cmd_q)
          CMD_SUB_RESET:        cmd_bus.rst_stb <= 1'b1;
          CMD_CLK_500, CMD_CLK_160, CMD_CLK_400, CMD_CLK_1000: cmd_bus.clk_stb <= 1'b1;
          CMD_ZERO_FORCE:       zero_mode_o <= ZM_FORCE;
          CMD_ZERO_FORCE_RESET: zero_mode_o <= ZM_FORCE_RST;
          CMD_ZERO_RELEASE:     zero_mode_o <= ZM_PASS;
          // Fuse escalation is never withdrawn short of a reset
          CMD_FC_ESCALATE:      fc_esc_o <= 1'b1;
          CMD_SCRAP_ESC0:       scrap_esc0_o <= 1'b1;
          CMD_SCRAP_ESC0_DIS:   scrap_esc0_o <= 1'b0;
          CMD_SCRAP_ESC1:       scrap_esc1_o <= 1'b1;
          CMD_SCRAP_ESC1_DIS:   scrap_esc1_o <= 1'b0;
          CMD_SVA_DISABLE:      sva_disable_o <= 1'b1;
          CMD_SVA_ENABLE:       sva_disable_o <= 1'b0;
          CMD_FAULT_CORR:       cmd_bus.fault_corr_stb <= 1'b1;
          CMD_FAULT_UNCORR:     cmd_bus.fault_uncorr_stb <= 1'b1;
          CMD_FAULT_DIGEST:     cmd_bus.digest_clr_stb <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  //------------------------------------------------------------------------
  // Zeroization override mux
  //------------------------------------------------------------------------
  always_comb begin
    zeroize_ppd_o   = zeroize_ppd_i;
    scrap_mode_o    = scrap_mode_i;
    rom_zero_mask_o = rom_zero_mask_i;
    case (zero_mode_o)
      ZM_FORCE: begin
        zeroize_ppd_o   = 1'b1;
        scrap_mode_o    = 1'b0;
        rom_zero_mask_o = '1;
      end
      ZM_FORCE_RST: begin
        zeroize_ppd_o   = 1'b0;
        scrap_mode_o    = 1'b1;
        rom_zero_mask_o = '0;
      end
      default: ;
    endcase
  end

  // Service blocks rely on never seeing two commands at once
  a_one_strobe: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    $onehot0({cmd_bus.rst_stb, cmd_bus.clk_stb, cmd_bus.fault_corr_stb,
              cmd_bus.fault_uncorr_stb, cmd_bus.digest_clr_stb}));

endmodule

`default_nettype wire

//--- design/sub_reset_sequencer.sv
//--------------------------------------------------------------------------
// Pulse is RST_HOLD_CYCLES long; requests during a pulse are dropped
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sub_reset_sequencer
  import fc_lcc_svc_pkg::*;
(
  input  logic           clk,
  input  logic           cptra_rst_b,
  svc_cmd_if.rst_sink    cmd_bus,
  output logic           sub_rst_b_o
);

  // Counts the cycles already spent in reset, 1 on the first one
  rst_cnt_t hold_cnt;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      sub_rst_b_o <= 1'b1;
      hold_cnt    <= '0;
    end else if (!sub_rst_b_o) begin
      if (hold_cnt == RST_HOLD_CNT) begin
        sub_rst_b_o <= 1'b1;
        hold_cnt    <= '0;
      end else begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end else if (cmd_bus.rst_stb) begin
      sub_rst_b_o <= 1'b0;
      hold_cnt    <= rst_cnt_t'(1);
    end
  end

  a_cnt_bound: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    hold_cnt <= RST_HOLD_CNT);

endmodule

`default_nettype wire

//--- design/ext_clk_switch_ctrl.sv
//--------------------------------------------------------------------------
// Only a frequency code is produced; no clock is generated here
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module ext_clk_switch_ctrl
  import fc_lcc_svc_pkg::*;
(
  input  logic        clk,
  input  logic        cptra_rst_b,
  svc_cmd_if.clk_sink cmd_bus,
  input  logic        clk_byp_ack_i,
  output clk_sel_t    clk_sel_o,
  output logic        clk_switch_req_o
);

  logic req_pending;

  // The request is held back until the bypass is acknowledged
  assign clk_switch_req_o = req_pending & clk_byp_ack_i;

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      clk_sel_o   <= CLK_SEL_1000;
      req_pending <= 1'b0;
    end else if (cmd_bus.clk_stb) begin
      clk_sel_o   <= cmd_bus.clk_code;
      req_pending <= 1'b1;
    end else if (clk_switch_req_o) begin
      // Clock source has seen the request
      req_pending <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- design/otp_fault_injector.sv
//--------------------------------------------------------------------------
// One fault per reset: the first fault command arms the overlay for good
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module otp_fault_injector
  import fc_lcc_svc_pkg::*;
(
  input  logic          clk,
  input  logic          cptra_rst_b,
  svc_cmd_if.fault_sink cmd_bus,
  otp_fault_if.inject   fault_bus
);

  otp_word_t [NUM_PARTS-1:0] fault_word_d;
  logic                      arm;

  assign arm = (cmd_bus.fault_corr_stb | cmd_bus.fault_uncorr_stb) & ~fault_bus.fault_active;

  // Unlocked partitions see an all-zero mask and keep their raw word
  always_comb begin
    for (int p = 0; p < NUM_PARTS; p++) begin
      if (cmd_bus.fault_corr_stb) begin
        fault_word_d[p] = fault_bus.part_word[p] ^ otp_word_t'(fault_bus.digest_nz[p]);
      end else begin
        fault_word_d[p] = fault_bus.part_word[p] ^
                          {$bits(otp_word_t){fault_bus.digest_nz[p]}};
      end
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      fault_bus.fault_active <= 1'b0;
      fault_bus.digest_clr   <= 1'b0;
    end else begin
      if (arm) begin
        fault_bus.fault_active <= 1'b1;
      end
      if (cmd_bus.digest_clr_stb) begin
        fault_bus.digest_clr <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (arm) begin
      fault_bus.faulted_word <= fault_word_d;
    end
  end

  // Later writes to the store must not leak into an armed overlay
  a_overlay_frozen: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    fault_bus.fault_active |=> $stable(fault_bus.faulted_word));

endmodule

`default_nettype wire

//--- design/otp_partition_store.sv
//--------------------------------------------------------------------------
// Array has no reset and reads combinationally through the fault overlay
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module otp_partition_store
  import fc_lcc_svc_pkg::*;
(
  input  logic       clk,
  input  logic       cptra_rst_b,
  input  logic       wr_en_i,
  input  otp_addr_t  wr_addr_i,
  input  otp_word_t  wr_data_i,
  input  otp_addr_t  rd_addr_i,
  output otp_word_t  rd_data_o,
  otp_fault_if.store fault_bus
);

  otp_word_t mem [OTP_WORDS];
  part_idx_t rd_part;
  logic      rd_first;

  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      mem[wr_addr_i] <= wr_data_i;
    end
  end

  for (genvar p = 0; p < NUM_PARTS; p++) begin : g_part
    localparam otp_addr_t BASE   = otp_addr_t'(p * PART_WORDS);
    localparam otp_addr_t DIGEST = otp_addr_t'(p * PART_WORDS + PART_WORDS - 1);

    assign fault_bus.part_word[p] = mem[BASE];
    assign fault_bus.digest_nz[p] = |mem[DIGEST];

    // An unlocked partition is captured unchanged when the injector arms
    a_unlocked_raw: assert property (@(posedge clk) disable iff (!cptra_rst_b)
      $rose(fault_bus.fault_active) && !$past(fault_bus.digest_nz[p]) |->
        fault_bus.faulted_word[p] == $past(fault_bus.part_word[p]));
  end

  //------------------------------------------------------------------------
  // Read path
  //------------------------------------------------------------------------
  assign rd_part  = rd_addr_i[$bits(otp_addr_t)-1:PART_SHIFT];
  assign rd_first = (rd_addr_i[PART_SHIFT-1:0] == '0);

  always_comb begin
    rd_data_o = mem[rd_addr_i];
    if (fault_bus.fault_active && rd_first && rd_part <= LAST_PART) begin
      rd_data_o = fault_bus.faulted_word[rd_part];
    end
    if (fault_bus.digest_clr && rd_addr_i == LC_DIGEST_ADDR) begin
      rd_data_o = '0;
    end
  end

endmodule

`default_nettype wire

//--- design/fc_lcc_svc_top.sv
//--------------------------------------------------------------------------
// Test-service controller; commands are single-cycle with no ready
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fc_lcc_svc_top
  import fc_lcc_svc_pkg::*;
(
  input  logic      clk,
  input  logic      cptra_rst_b,
  input  logic      cmd_valid_i,
  input  svc_cmd_t  cmd_i,
  input  logic      clk_byp_ack_i,
  input  logic      zeroize_ppd_i,
  input  logic      scrap_mode_i,
  input  rom_mask_t rom_zero_mask_i,
  input  logic      otp_wr_en_i,
  input  otp_addr_t otp_wr_addr_i,
  input  otp_word_t otp_wr_data_i,
  input  otp_addr_t otp_rd_addr_i,
  output otp_word_t otp_rd_data_o,
  output logic      sub_rst_b_o,
  output clk_sel_t  clk_sel_o,
  output logic      clk_switch_req_o,
  output logic      fc_esc_o,
  output logic      scrap_esc0_o,
  output logic      scrap_esc1_o,
  output logic      sva_disable_o,
  output logic      zeroize_ppd_o,
  output logic      scrap_mode_o,
  output rom_mask_t rom_zero_mask_o
);

  svc_cmd_if   i_cmd_bus ();
  otp_fault_if i_fault_bus ();

  svc_cmd_decoder i_svc_cmd_decoder (
    .clk             (clk),
    .cptra_rst_b     (cptra_rst_b),
    .cmd_valid_i     (cmd_valid_i),
    .cmd_i           (cmd_i),
    .zeroize_ppd_i   (zeroize_ppd_i),
    .scrap_mode_i    (scrap_mode_i),
    .rom_zero_mask_i (rom_zero_mask_i),
    .cmd_bus         (i_cmd_bus),
    .fc_esc_o        (fc_esc_o),
    .scrap_esc0_o    (scrap_esc0_o),
    .scrap_esc1_o    (scrap_esc1_o),
    .sva_disable_o   (sva_disable_o),
    .zero_mode_o     (),
    .zeroize_ppd_o   (zeroize_ppd_o),
    .scrap_mode_o    (scrap_mode_o),
    .rom_zero_mask_o (rom_zero_mask_o)
  );

  sub_reset_sequencer i_sub_reset_sequencer (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_bus     (i_cmd_bus),
    .sub_rst_b_o (sub_rst_b_o)
  );

  ext_clk_switch_ctrl i_ext_clk_switch_ctrl (
    .clk              (clk),
    .cptra_rst_b      (cptra_rst_b),
    .cmd_bus          (i_cmd_bus),
    .clk_byp_ack_i    (clk_byp_ack_i),
    .clk_sel_o        (clk_sel_o),
    .clk_switch_req_o (clk_switch_req_o)
  );

  otp_fault_injector i_otp_fault_injector (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_bus     (i_cmd_bus),
    .fault_bus   (i_fault_bus)
  );

  otp_partition_store i_otp_partition_store (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .wr_en_i     (otp_wr_en_i),
    .wr_addr_i   (otp_wr_addr_i),
    .wr_data_i   (otp_wr_data_i),
    .rd_addr_i   (otp_rd_addr_i),
    .rd_data_o   (otp_rd_data_o),
    .fault_bus   (i_fault_bus)
  );

endmodule

`default_nettype wire

//--- testbench/tb_clk_gen.sv
//--------------------------------------------------------------------------
// Reset is held for 8 cycles at start and again after each rst_req_i rise
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  input  logic rst_req_i,
  output logic clk_o,
  output logic rst_b_o
);

  localparam int HALF_PERIOD_NS = 10;
  localparam int RST_CYCLES     = 8;

  initial begin
    clk_o = 1'b0;
    forever #(HALF_PERIOD_NS) clk_o = ~clk_o;
  end

  // Reset edges fall on the falling clock edge, away from the sampling edge
  initial begin
    rst_b_o = 1'b0;
    repeat (RST_CYCLES) @(negedge clk_o);
    rst_b_o = 1'b1;
    forever begin
      @(posedge rst_req_i);
      @(negedge clk_o);
      rst_b_o = 1'b0;
      repeat (RST_CYCLES) @(negedge clk_o);
      rst_b_o = 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- testbench/fc_lcc_svc_tb.sv
//--------------------------------------------------------------------------
// Checks run as concurrent assertions against a cycle model of the command
// timing; OTP reads are only compared after the whole store is written
//--------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module fc_lcc_svc_tb
  import fc_lcc_svc_pkg::*;
();

  // The watchdog limit is the sum of the per-test cycle budgets plus a margin
  localparam int CYC_RESET   = 60;
  localparam int CYC_CLK     = 60;
  localparam int CYC_ZERO    = 40;
  localparam int CYC_FLAGS   = 60;
  localparam int CYC_FAULT   = 620;
  localparam int CYC_DIGEST  = 90;
  localparam int CYC_MARGIN  = 200;
  localparam int WATCHDOG_NS =
    (CYC_RESET + CYC_CLK + CYC_ZERO + CYC_FLAGS + CYC_FAULT + CYC_DIGEST + CYC_MARGIN) * 20;
  localparam int LC_DIGEST   = LC_TRANS_PART * PART_WORDS + PART_WORDS - 1;

  logic clk, cptra_rst_b, rst_req;
  logic cmd_valid_i, clk_byp_ack_i, zeroize_ppd_i, scrap_mode_i, otp_wr_en_i;
  svc_cmd_t cmd_i;
  rom_mask_t rom_zero_mask_i, rom_zero_mask_o;
  otp_addr_t otp_wr_addr_i, otp_rd_addr_i;
  otp_word_t otp_wr_data_i, otp_rd_data_o;
  logic sub_rst_b_o, clk_switch_req_o, fc_esc_o, scrap_esc0_o, scrap_esc1_o;
  logic sva_disable_o, zeroize_ppd_o, scrap_mode_o;
  clk_sel_t clk_sel_o;

  int err_cnt, test_err_start, tests_run, tests_bad;
  string cur_name;
  logic [31:0] lfsr_state;
  logic rd_chk;

  tb_clk_gen i_tb_clk_gen (.rst_req_i(rst_req), .clk_o(clk), .rst_b_o(cptra_rst_b));

  fc_lcc_svc_top i_fc_lcc_svc_top (.*);

  //------------------------------------------------------------------------
  // Reference model with stage 1 at edge k+1 and stage 2 at edge k+2
  //------------------------------------------------------------------------
  logic m_valid, m_rst_go, m_clk_go, m_fault_go, m_fault_corr, m_dclr_go;
  logic m_fc_esc, m_esc0, m_esc1, m_sva_dis, m_pend, m_armed, m_dclr;
  svc_cmd_t m_cmd;
  clk_sel_t m_clk_code, m_clk_sel;
  zero_mode_t m_mode;
  int m_rst_cnt;
  otp_word_t shadow [OTP_WORDS];
  otp_word_t cap_word [NUM_PARTS];
  otp_word_t m_fw [NUM_PARTS];
  logic exp_zppd, exp_scrap;
  rom_mask_t exp_mask;
  otp_word_t exp_rd;

  function automatic clk_sel_t expected_clk_code(svc_cmd_t cmd);
    case (cmd)
      CMD_CLK_500:  return CLK_SEL_500;
      CMD_CLK_160:  return CLK_SEL_160;
      CMD_CLK_400:  return CLK_SEL_400;
      default:      return CLK_SEL_1000;
    endcase
  endfunction

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      m_valid      <= 1'b0;
      m_cmd        <= '0;
      m_rst_go     <= 1'b0;
      m_clk_go     <= 1'b0;
      m_clk_code   <= CLK_SEL_1000;
      m_fault_go   <= 1'b0;
      m_fault_corr <= 1'b0;
      m_dclr_go    <= 1'b0;
      m_fc_esc     <= 1'b0;
      m_esc0       <= 1'b0;
      m_esc1       <= 1'b0;
      m_sva_dis    <= 1'b0;
      m_mode       <= ZM_PASS;
      m_rst_cnt    <= 0;
      m_clk_sel    <= CLK_SEL_1000;
      m_pend       <= 1'b0;
      m_armed      <= 1'b0;
      m_dclr       <= 1'b0;
    end else begin
      m_valid      <= cmd_valid_i;
      m_cmd        <= cmd_i;
      m_rst_go     <= m_valid && m_cmd == CMD_SUB_RESET;
      m_clk_go     <= m_valid && (m_cmd inside {CMD_CLK_500, CMD_CLK_160, CMD_CLK_400,
                                                CMD_CLK_1000});
      m_clk_code   <= expected_clk_code(m_cmd);
      m_fault_go   <= m_valid && (m_cmd == CMD_FAULT_CORR || m_cmd == CMD_FAULT_UNCORR);
      m_fault_corr <= m_cmd == CMD_FAULT_CORR;
      m_dclr_go    <= m_valid && m_cmd == CMD_FAULT_DIGEST;
      if (m_valid) begin
        case (m_cmd)
          CMD_ZERO_FORCE:       m_mode <= ZM_FORCE;
          CMD_ZERO_FORCE_RESET: m_mode <= ZM_FORCE_RST;
          CMD_ZERO_RELEASE:     m_mode <= ZM_PASS;
          CMD_FC_ESCALATE:      m_fc_esc <= 1'b1;
          CMD_SCRAP_ESC0:       m_esc0 <= 1'b1;
          CMD_SCRAP_ESC0_DIS:   m_esc0 <= 1'b0;
          CMD_SCRAP_ESC1:       m_esc1 <= 1'b1;
          CMD_SCRAP_ESC1_DIS:   m_esc1 <= 1'b0;
          CMD_SVA_DISABLE:      m_sva_dis <= 1'b1;
          CMD_SVA_ENABLE:       m_sva_dis <= 1'b0;
          default: ;
        endcase
      end
      // Stage 2 responses
      if (m_rst_cnt != 0) begin
        m_rst_cnt <= m_rst_cnt - 1;
      end else if (m_rst_go) begin
        m_rst_cnt <= RST_HOLD_CYCLES;
      end
      if (m_clk_go) begin
        m_clk_sel <= m_clk_code;
        m_pend    <= 1'b1;
      end else if (m_pend && clk_byp_ack_i) begin
        m_pend <= 1'b0;
      end
      if (m_fault_go && !m_armed) begin
        m_armed <= 1'b1;
        m_fw    <= cap_word;
      end
      if (m_dclr_go) begin
        m_dclr <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (otp_wr_en_i) shadow[otp_wr_addr_i] <= otp_wr_data_i;
  end

  // Locked partitions get bit 0 flipped or the whole first word inverted
  always_comb begin
    for (int p = 0; p < NUM_PARTS; p++) begin
      cap_word[p] = shadow[p * PART_WORDS];
      if (shadow[p * PART_WORDS + PART_WORDS - 1] != '0) begin
        cap_word[p] = m_fault_corr ? cap_word[p] ^ 16'h0001 : ~cap_word[p];
      end
    end
  end

  always_comb begin
    exp_zppd  = zeroize_ppd_i;
    exp_scrap = scrap_mode_i;
    exp_mask  = rom_zero_mask_i;
    if (m_mode == ZM_FORCE) begin
      exp_zppd  = 1'b1;
      exp_scrap = 1'b0;
      exp_mask  = '1;
    end else if (m_mode == ZM_FORCE_RST) begin
      exp_zppd  = 1'b0;
      exp_scrap = 1'b1;
      exp_mask  = '0;
    end
  end

  always_comb begin
    int a;
    a = int'(otp_rd_addr_i);
    exp_rd = shadow[otp_rd_addr_i];
    if (m_armed && a % PART_WORDS == 0 && a / PART_WORDS < NUM_PARTS) begin
      exp_rd = m_fw[a / PART_WORDS];
    end
    if (m_dclr && a == LC_DIGEST) begin
      exp_rd = '0;
    end
  end

  //------------------------------------------------------------------------
  // Checks
  //------------------------------------------------------------------------
  task automatic record_failure(input string msg);
    err_cnt++;
    $display("FAILED %0t: %s", $time, msg);
  endtask

  chk_sub_rst: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    sub_rst_b_o == (m_rst_cnt == 0))
    else record_failure("sub_rst_b_o off the 11-cycle pulse");
  chk_clk_sel: assert property (@(posedge clk) disable iff (!cptra_rst_b) clk_sel_o == m_clk_sel)
    else record_failure("clk_sel_o has the wrong code");
  chk_clk_req: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    clk_switch_req_o == (m_pend && clk_byp_ack_i))
    else record_failure("clk_switch_req_o mismatch");
  chk_flags: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    {fc_esc_o, scrap_esc0_o, scrap_esc1_o, sva_disable_o} == {m_fc_esc, m_esc0, m_esc1, m_sva_dis})
    else record_failure("escalation or SVA flag mismatch");
  chk_esc_sticky: assert property (@(posedge clk) disable iff (!cptra_rst_b) !$fell(fc_esc_o))
    else record_failure("fc_esc_o cleared without reset");
  chk_zero: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    {zeroize_ppd_o, scrap_mode_o, rom_zero_mask_o} == {exp_zppd, exp_scrap, exp_mask})
    else record_failure("zeroization outputs mismatch");
  chk_rd: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    !rd_chk || otp_rd_data_o == exp_rd)
    else record_failure($sformatf("OTP word %0d read wrong", otp_rd_addr_i));

  //------------------------------------------------------------------------
  // Stimulus helpers
  //------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    return s[0] ? (s >> 1) ^ 32'h8020_0003 : s >> 1;
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      val[i] = lfsr_state[0];
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // Between commands cmd_i carries junk with valid low
  task automatic send_cmd(input svc_cmd_t cmd);
    logic [31:0] junk;
    @(negedge clk);
    cmd_valid_i = 1'b1;
    cmd_i = cmd;
    @(negedge clk);
    take_bits(8, junk);
    cmd_valid_i = 1'b0;
    cmd_i = junk[7:0];
  endtask

  task automatic shuffle_zero_inputs();
    logic [31:0] bits;
    @(negedge clk);
    take_bits(2, bits);
    zeroize_ppd_i = bits[0];
    scrap_mode_i  = bits[1];
    take_bits(32, bits);
    rom_zero_mask_i = bits;
  endtask

  // Digests are nonzero only in the partitions set in lock_mask
  task automatic fill_store(input logic [NUM_PARTS-1:0] lock_mask);
    logic [31:0] w;
    for (int a = 0; a < OTP_WORDS; a++) begin
      take_bits(16, w);
      if (a % PART_WORDS == PART_WORDS - 1 && a / PART_WORDS < NUM_PARTS) begin
        if (!lock_mask[a / PART_WORDS]) w = '0;
        else if (w[15:0] == '0) w = 32'h1;
      end
      @(negedge clk);
      otp_wr_en_i   = 1'b1;
      otp_wr_addr_i = otp_addr_t'(a);
      otp_wr_data_i = w[15:0];
    end
    @(negedge clk);
    otp_wr_en_i = 1'b0;
  endtask

  task automatic sweep_reads();
    for (int a = 0; a < OTP_WORDS; a++) begin
      @(negedge clk);
      otp_rd_addr_i = otp_addr_t'(a);
    end
    @(negedge clk);
  endtask

  task automatic fault_run(input svc_cmd_t first, input svc_cmd_t second,
                           input logic [NUM_PARTS-1:0] lock_mask);
    fill_store(lock_mask);
    rd_chk = 1'b1;
    sweep_reads();
    send_cmd(first);
    wait_cycles(3);
    sweep_reads();
    send_cmd(second);
    wait_cycles(3);
    sweep_reads();
  endtask

  task automatic reset_design();
    @(negedge clk);
    rst_req = 1'b1;
    @(negedge clk);
    rst_req = 1'b0;
    wait (cptra_rst_b === 1'b0);
    wait (cptra_rst_b === 1'b1);
    @(negedge clk);
  endtask

  task automatic start_test(input string name);
    cur_name = name;
    test_err_start = err_cnt;
  endtask

  task automatic finish_test();
    tests_run++;
    if (err_cnt != test_err_start) tests_bad++;
    $display("%s: %0d check errors", cur_name, err_cnt - test_err_start);
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired before the tests completed");
    $display("test failed");
    $finish;
  end

  initial begin
    lfsr_state      = 32'hfa88_2929;
    err_cnt         = 0;
    tests_run       = 0;
    tests_bad       = 0;
    rd_chk          = 1'b0;
    rst_req         = 1'b0;
    cmd_valid_i     = 1'b0;
    cmd_i           = '0;
    clk_byp_ack_i   = 1'b0;
    zeroize_ppd_i   = 1'b0;
    scrap_mode_i    = 1'b0;
    rom_zero_mask_i = '0;
    otp_wr_en_i     = 1'b0;
    otp_wr_addr_i   = '0;
    otp_wr_data_i   = '0;
    otp_rd_addr_i   = '0;
    wait (cptra_rst_b === 1'b1);
    @(negedge clk);

    start_test("sub reset pulse");
    send_cmd(CMD_SUB_RESET);
    wait_cycles(4);
    send_cmd(CMD_SUB_RESET);
    wait_cycles(18);
    send_cmd(CMD_SUB_RESET);
    wait_cycles(16);
    finish_test();

    start_test("clock switch");
    clk_byp_ack_i = 1'b1;
    send_cmd(CMD_CLK_500);
    wait_cycles(5);
    send_cmd(CMD_CLK_400);
    wait_cycles(5);
    clk_byp_ack_i = 1'b0;
    send_cmd(CMD_CLK_160);
    wait_cycles(8);
    clk_byp_ack_i = 1'b1;
    wait_cycles(4);
    send_cmd(CMD_CLK_1000);
    wait_cycles(5);
    finish_test();

    start_test("zeroization override");
    shuffle_zero_inputs();
    send_cmd(CMD_ZERO_FORCE);
    wait_cycles(2);
    shuffle_zero_inputs();
    send_cmd(CMD_ZERO_FORCE_RESET);
    wait_cycles(2);
    shuffle_zero_inputs();
    send_cmd(CMD_ZERO_RELEASE);
    wait_cycles(2);
    shuffle_zero_inputs();
    wait_cycles(2);
    finish_test();

    start_test("escalation flags");
    send_cmd(CMD_FC_ESCALATE);
    send_cmd(CMD_SCRAP_ESC0);
    send_cmd(CMD_SCRAP_ESC1);
    send_cmd(CMD_SVA_DISABLE);
    send_cmd(8'hA5);
    send_cmd(CMD_SCRAP_ESC0_DIS);
    send_cmd(CMD_SVA_ENABLE);
    send_cmd(8'hFF);
    send_cmd(CMD_SCRAP_ESC1_DIS);
    send_cmd(8'h00);
    wait_cycles(4);
    finish_test();

    start_test("fault injection");
    fault_run(CMD_FAULT_CORR, CMD_FAULT_UNCORR, 7'b0101101);
    reset_design();
    fault_run(CMD_FAULT_UNCORR, CMD_FAULT_CORR, 7'b0110011);
    finish_test();

    start_test("digest clear");
    send_cmd(CMD_FAULT_DIGEST);
    wait_cycles(3);
    sweep_reads();
    finish_test();

    $display("Summary: %0d tests run, %0d with errors, %0d check errors in total",
             tests_run, tests_bad, err_cnt);
    if (err_cnt == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
design/fc_lcc_svc_pkg.sv
design/svc_cmd_if.sv
design/otp_fault_if.sv
design/svc_cmd_decoder.sv
design/sub_reset_sequencer.sv
design/ext_clk_switch_ctrl.sv
design/otp_fault_injector.sv
design/otp_partition_store.sv
design/fc_lcc_svc_top.sv
testbench/tb_clk_gen.sv
testbench/fc_lcc_svc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only on the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module fc_lcc_svc_tb \
  -f filelist.f -o fc_lcc_svc_sim
out=$(./obj_dir/fc_lcc_svc_sim)
echo "$out"
echo "$out" | grep -qx "test passed"
